// File: logic/qla_config.svh
// qla motor controller constants for widths, channel count and dac timing
`ifndef QLA_CONFIG_SVH
`define QLA_CONFIG_SVH

// ---------------------------------------------------------------------
// bus and channel sizing
// ---------------------------------------------------------------------
`define QLA_NUM_CHAN        4           // motor axes on the board
`define QLA_CUR_W           16          // current command and feedback sample
`define QLA_DATA_W          32          // wishbone data
`define QLA_ADDR_W          8           // bits 7..4 channel, bits 3..0 offset

// ---------------------------------------------------------------------
// safety check
// ---------------------------------------------------------------------
`define QLA_SAFETY_MARGIN   16'h1000    // allowed feedback above command
`define QLA_SAFETY_PERSIST  4           // faulty cycles in a row before trip

// ---------------------------------------------------------------------
// dac serial link
// ---------------------------------------------------------------------
`define QLA_DAC_SCLK_DIV    2           // sysclk cycles per sclk half period
`define QLA_DAC_FRAME_BITS  24          // cmd + addr + data
`define QLA_DAC_CMD_UPDATE  4'b0011     // write input reg and update output

`endif

// File: logic/qla_pkg.sv
// shared types for the qla register map, dac sequencing and channel status
`include "qla_config.svh"

package qla_pkg;

    // offset within a channel's register block, address bits 3..0
    typedef enum logic [3:0] {
        OFF_DAC_CTRL     = 4'd0,    // commanded current
        OFF_MOTOR_STATUS = 4'd1     // status word, write bit 0 for amp enable
    } reg_off_e;

    // board control sits at offset 0 of channel 0
    localparam reg_off_e OFF_BOARD_CTRL = OFF_DAC_CTRL;

    // dac update sequencer
    typedef enum logic [1:0] {
        DAC_IDLE,
        DAC_LOAD,       // build next frame, pull csn low
        DAC_SHIFT,      // clock out the frame
        DAC_GAP         // csn high between frames
    } dac_state_e;

    // per-channel status as read back by the host
    typedef struct packed {
        logic [`QLA_DATA_W-`QLA_CUR_W-3:0] rsvd;        // reads as zero
        logic                              amp_enable;
        logic                              safety_trip;
        logic [`QLA_CUR_W-1:0]             cur_cmd;
    } chan_status_t;

endpackage

// File: logic/reg_bus_if.sv
// register write bus from the wishbone decoder to the motor channels
`timescale 1ns/1ps
`include "qla_config.svh"

interface reg_bus_if;

    logic                   wen;    // one-cycle strobe, lines up with ack
    logic [3:0]             chan;   // 0 = board, 1..4 = axis
    qla_pkg::reg_off_e      off;
    logic [`QLA_DATA_W-1:0] wdata;

    modport decoder (
        output wen,
        output chan,
        output off,
        output wdata
    );

    modport channel (
        input wen,
        input chan,
        input off,
        input wdata
    );

endinterface

// File: logic/wb_reg_decode.sv
// wishbone classic slave with address decode, write bus, read mux and board control
`timescale 1ns/1ps
`include "qla_config.svh"

module wb_reg_decode (
    input  logic                   sysclk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`QLA_ADDR_W-1:0] wb_adr,
    input  logic [`QLA_DATA_W-1:0] wb_dat_i,
    input  qla_pkg::chan_status_t  chan_stat [1:`QLA_NUM_CHAN],
    input  logic                   dac_busy,
    output logic [`QLA_DATA_W-1:0] wb_dat_o,
    output logic                   wb_ack,
    output logic                   clear_all,
    output logic                   dac_req,
    reg_bus_if.decoder             bus
);

    logic [3:0]             adr_chan;
    qla_pkg::reg_off_e      adr_off;
    logic                   acc;        // fresh access, not yet acked
    logic                   chan_hit;   // address falls on an axis 1..4
    logic [`QLA_DATA_W-1:0] rd_mux;

    assign adr_chan = wb_adr[7:4];
    assign adr_off  = qla_pkg::reg_off_e'(wb_adr[3:0]);
    assign acc      = wb_cyc && wb_stb && !wb_ack;
    assign chan_hit = (adr_chan != 4'd0) && (adr_chan <= 4'(`QLA_NUM_CHAN));

    // ---------------------------------------------------------------------
    // handshake and write strobes
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            bus.wen   <= 1'b0;
            clear_all <= 1'b0;
            dac_req   <= 1'b0;
        end else begin
            wb_ack    <= acc;           // single cycle, held stb is ignored
            bus.wen   <= acc && wb_we;
            // board control, bit 0 clears every latched trip
            clear_all <= acc && wb_we && (adr_chan == 4'd0)
                         && (adr_off == qla_pkg::OFF_BOARD_CTRL) && wb_dat_i[0];
            // any command write kicks the dac
            dac_req   <= acc && wb_we && chan_hit && (adr_off == qla_pkg::OFF_DAC_CTRL);
        end
    end

    // payload captured alongside ack
    always_ff @(posedge sysclk) begin
        if (acc) begin
            bus.chan  <= adr_chan;
            bus.off   <= adr_off;
            bus.wdata <= wb_dat_i;
            wb_dat_o  <= rd_mux;        // valid while ack is high
        end
    end

    // ---------------------------------------------------------------------
    // read mux
    // ---------------------------------------------------------------------
    always_comb begin
        rd_mux = '0;                    // unmapped reads return zero
        if (adr_chan == 4'd0) begin
            if (adr_off == qla_pkg::OFF_BOARD_CTRL) begin
                rd_mux[2*`QLA_NUM_CHAN] = dac_busy;
                for (int k = 1; k <= `QLA_NUM_CHAN; k++) begin
                    rd_mux[`QLA_NUM_CHAN+k-1] = chan_stat[k].safety_trip;
                    rd_mux[k-1]               = chan_stat[k].amp_enable;
                end
            end
        end else if (chan_hit) begin
            case (adr_off)
                qla_pkg::OFF_DAC_CTRL: begin
                    rd_mux = `QLA_DATA_W'(chan_stat[adr_chan].cur_cmd);
                end
                qla_pkg::OFF_MOTOR_STATUS: begin
                    rd_mux = chan_stat[adr_chan];
                end
                default: begin
                    rd_mux = '0;
                end
            endcase
        end
    end

    // master drops stb after ack, so ack never stretches
    a_ack_one_cycle: assert property (@(posedge sysclk) disable iff (rst)
        wb_ack |=> !wb_ack);

endmodule

// File: logic/motor_channel.sv
// one motor axis holding current command, amp enable and a latched overcurrent trip
`timescale 1ns/1ps
`include "qla_config.svh"

module motor_channel #(
    parameter int CHANNEL = 1           // axis number, matches address bits 7..4
) (
    input  logic                  sysclk,
    input  logic                  rst,
    reg_bus_if.channel            bus,
    input  logic                  clear_all,
    input  logic [`QLA_CUR_W-1:0] cur_fb,
    output qla_pkg::chan_status_t status
);

    localparam int PERSIST_W = $clog2(`QLA_SAFETY_PERSIST + 1);

    logic [`QLA_CUR_W-1:0] cur_cmd;
    logic                  amp_en;
    logic                  trip;
    logic [PERSIST_W-1:0]  persist_cnt;   // saturates at the persist limit
    logic [`QLA_CUR_W:0]   fb_limit;      // extra bit so command + margin never wraps
    logic                  fb_over;
    logic                  trip_hit;
    logic                  wr_sel;

    assign wr_sel   = bus.wen && (bus.chan == 4'(CHANNEL));
    assign fb_limit = {1'b0, cur_cmd} + {1'b0, `QLA_SAFETY_MARGIN};
    assign fb_over  = {1'b0, cur_fb} > fb_limit;
    assign trip_hit = fb_over && (persist_cnt >= PERSIST_W'(`QLA_SAFETY_PERSIST - 1));

    // ---------------------------------------------------------------------
    // safety persistence
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            persist_cnt <= '0;
        end else if (!fb_over) begin
            persist_cnt <= '0;          // any good sample restarts the count
        end else if (persist_cnt != PERSIST_W'(`QLA_SAFETY_PERSIST)) begin
            persist_cnt <= persist_cnt + 1'b1;
        end
    end

    // ---------------------------------------------------------------------
    // command, enable and trip
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cur_cmd <= '0;
            amp_en  <= 1'b0;
            trip    <= 1'b0;
        end else begin
            if (clear_all) begin
                trip <= 1'b0;           // enable stays where it is, off if tripped
            end
            if (wr_sel && (bus.off == qla_pkg::OFF_DAC_CTRL)) begin
                cur_cmd <= bus.wdata[`QLA_CUR_W-1:0];
            end
            if (wr_sel && (bus.off == qla_pkg::OFF_MOTOR_STATUS)) begin
                amp_en <= bus.wdata[0];
                if (bus.wdata[0]) begin
                    trip <= 1'b0;       // re-enable acknowledges the fault
                end
            end
            // trip wins over a same-cycle enable
            if (trip_hit) begin
                amp_en <= 1'b0;
                trip   <= 1'b1;
            end
        end
    end

    always_comb begin
        status             = '0;
        status.amp_enable  = amp_en;
        status.safety_trip = trip;
        status.cur_cmd     = cur_cmd;
    end

    a_no_enable_when_tripped: assert property (@(posedge sysclk) disable iff (rst)
        !(amp_en && trip));

endmodule

// File: logic/dac_update_fsm.sv
// dac update sequencer sending the four axis commands as serial frames
`timescale 1ns/1ps
`include "qla_config.svh"

module dac_update_fsm (
    input  logic                  sysclk,
    input  logic                  rst,
    input  logic                  dac_req,
    input  logic [`QLA_CUR_W-1:0] cur_cmd [1:`QLA_NUM_CHAN],
    input  logic                  tmr_edge,
    input  logic                  tmr_done,
    output logic                  tmr_start,
    output logic                  dac_busy,
    output logic                  dac_sclk,
    output logic                  dac_mosi,
    output logic                  dac_csn
);

    localparam int FW = `QLA_DAC_FRAME_BITS;

    qla_pkg::dac_state_e   state;
    logic [1:0]            frame_idx;     // dac channel address, axis minus one
    logic                  pending;       // write seen while busy
    logic [FW-1:0]         sreg;          // msb goes out first
    logic [`QLA_CUR_W-1:0] snap [2:`QLA_NUM_CHAN];
    logic [`QLA_CUR_W-1:0] frame_cmd;
    logic                  last_frame;

    // frame 0 uses the live command, later frames the copy taken with it
    assign frame_cmd  = (frame_idx == 2'd0) ? cur_cmd[1] : snap[3'(frame_idx) + 3'd1];
    assign last_frame = (frame_idx == 2'(`QLA_NUM_CHAN - 1));
    assign tmr_start  = (state == qla_pkg::DAC_LOAD);   // timer runs alongside csn low
    assign dac_busy   = (state != qla_pkg::DAC_IDLE) || pending;
    assign dac_mosi   = sreg[FW-1];

    // ---------------------------------------------------------------------
    // sequencing
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state     <= qla_pkg::DAC_IDLE;
            frame_idx <= 2'd0;
            pending   <= 1'b0;
            dac_sclk  <= 1'b0;
            dac_csn   <= 1'b1;
        end else begin
            if (dac_req && (state != qla_pkg::DAC_IDLE)) begin
                pending <= 1'b1;
            end
            case (state)
                qla_pkg::DAC_IDLE: begin
                    if (dac_req || pending) begin
                        pending   <= 1'b0;
                        frame_idx <= 2'd0;
                        state     <= qla_pkg::DAC_LOAD;
                    end
                end
                qla_pkg::DAC_LOAD: begin
                    dac_csn  <= 1'b0;
                    dac_sclk <= 1'b0;
                    state    <= qla_pkg::DAC_SHIFT;
                end
                qla_pkg::DAC_SHIFT: begin
                    if (tmr_edge) begin
                        dac_sclk <= ~dac_sclk;
                    end
                    if (tmr_done) begin         // last edge is a falling one
                        dac_csn  <= 1'b1;
                        dac_sclk <= 1'b0;
                        state    <= qla_pkg::DAC_GAP;
                    end
                end
                qla_pkg::DAC_GAP: begin
                    if (last_frame) begin
                        state <= qla_pkg::DAC_IDLE;
                    end else begin
                        frame_idx <= frame_idx + 2'd1;
                        state     <= qla_pkg::DAC_LOAD;
                    end
                end
                default: begin
                    state <= qla_pkg::DAC_IDLE;
                end
            endcase
        end
    end

    // frame data path
    always_ff @(posedge sysclk) begin
        if (state == qla_pkg::DAC_LOAD) begin
            sreg <= {`QLA_DAC_CMD_UPDATE, 2'b00, frame_idx, frame_cmd};
            if (frame_idx == 2'd0) begin
                for (int k = 2; k <= `QLA_NUM_CHAN; k++) begin
                    snap[k] <= cur_cmd[k];
                end
            end
        end else if ((state == qla_pkg::DAC_SHIFT) && tmr_edge && dac_sclk) begin
            sreg <= {sreg[FW-2:0], 1'b0};   // advance on falling sclk
        end
    end

    a_sclk_low_when_idle: assert property (@(posedge sysclk) disable iff (rst)
        dac_csn |-> !dac_sclk);

endmodule

// File: logic/spi_bit_timer.sv
// serial clock pacing with prescaled edge ticks and end-of-frame detect
`timescale 1ns/1ps
`include "qla_config.svh"

module spi_bit_timer (
    input  logic sysclk,
    input  logic rst,
    input  logic tmr_start,
    output logic tmr_edge,
    output logic tmr_done
);

    localparam int EDGES  = 2 * `QLA_DAC_FRAME_BITS;     // rise and fall per bit
    localparam int PRE_W  = $clog2(`QLA_DAC_SCLK_DIV + 1);
    localparam int EDGE_W = $clog2(EDGES);

    logic              running;
    logic [PRE_W-1:0]  pre_cnt;
    logic [EDGE_W-1:0] edge_cnt;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            running  <= 1'b0;
            pre_cnt  <= '0;
            edge_cnt <= '0;
            tmr_edge <= 1'b0;
            tmr_done <= 1'b0;
        end else begin
            tmr_edge <= 1'b0;
            tmr_done <= 1'b0;
            if (tmr_start) begin
                running  <= 1'b1;
                pre_cnt  <= '0;
                edge_cnt <= '0;
            end else if (running) begin
                if (pre_cnt == PRE_W'(`QLA_DAC_SCLK_DIV - 1)) begin
                    pre_cnt  <= '0;
                    tmr_edge <= 1'b1;       // one half period elapsed
                    if (edge_cnt == EDGE_W'(EDGES - 1)) begin
                        running  <= 1'b0;
                        tmr_done <= 1'b1;   // coincides with the final edge
                        edge_cnt <= '0;
                    end else begin
                        edge_cnt <= edge_cnt + 1'b1;
                    end
                end else begin
                    pre_cnt <= pre_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/qla_motor_ctrl.sv
// qla motor controller top with wishbone registers, four axes and dac update path
`timescale 1ns/1ps
`include "qla_config.svh"

module qla_motor_ctrl (
    input  logic                                     sysclk,
    input  logic                                     rst,
    // wishbone classic slave
    input  logic                                     wb_cyc,
    input  logic                                     wb_stb,
    input  logic                                     wb_we,
    input  logic [`QLA_ADDR_W-1:0]                   wb_adr,
    input  logic [`QLA_DATA_W-1:0]                   wb_dat_i,
    output logic [`QLA_DATA_W-1:0]                   wb_dat_o,
    output logic                                     wb_ack,
    // current feedback, axis 1 in the low bits
    input  logic [`QLA_NUM_CHAN-1:0][`QLA_CUR_W-1:0] cur_fb,
    output logic [`QLA_NUM_CHAN-1:0]                 amp_enable,
    // dac serial link
    output logic                                     dac_sclk,
    output logic                                     dac_mosi,
    output logic                                     dac_csn
);

    reg_bus_if reg_bus ();

    qla_pkg::chan_status_t chan_stat [1:`QLA_NUM_CHAN];
    logic [`QLA_CUR_W-1:0] cur_cmd   [1:`QLA_NUM_CHAN];
    logic                  clear_all;
    logic                  dac_req;
    logic                  dac_busy;
    logic                  tmr_start;
    logic                  tmr_edge;
    logic                  tmr_done;

    // ---------------------------------------------------------------------
    // host registers
    // ---------------------------------------------------------------------
    wb_reg_decode u_decode (
        .sysclk    (sysclk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .chan_stat (chan_stat),
        .dac_busy  (dac_busy),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .clear_all (clear_all),
        .dac_req   (dac_req),
        .bus       (reg_bus.decoder)
    );

    // axes 1..4
    generate
        for (genvar k = 1; k <= `QLA_NUM_CHAN; k++) begin : g_chan
            motor_channel #(.CHANNEL(k)) u_chan (
                .sysclk    (sysclk),
                .rst       (rst),
                .bus       (reg_bus.channel),
                .clear_all (clear_all),
                .cur_fb    (cur_fb[k-1]),
                .status    (chan_stat[k])
            );
            assign cur_cmd[k]      = chan_stat[k].cur_cmd;
            assign amp_enable[k-1] = chan_stat[k].amp_enable;
        end
    endgenerate

    // ---------------------------------------------------------------------
    // dac update
    // ---------------------------------------------------------------------
    dac_update_fsm u_dac_fsm (
        .sysclk    (sysclk),
        .rst       (rst),
        .dac_req   (dac_req),
        .cur_cmd   (cur_cmd),
        .tmr_edge  (tmr_edge),
        .tmr_done  (tmr_done),
        .tmr_start (tmr_start),
        .dac_busy  (dac_busy),
        .dac_sclk  (dac_sclk),
        .dac_mosi  (dac_mosi),
        .dac_csn   (dac_csn)
    );

    spi_bit_timer u_bit_timer (
        .sysclk    (sysclk),
        .rst       (rst),
        .tmr_start (tmr_start),
        .tmr_edge  (tmr_edge),
        .tmr_done  (tmr_done)
    );

endmodule

// File: test/tb_qla_motor_ctrl.sv
// directed testbench for the qla motor controller with wishbone tasks, dac monitor and watchdog
`timescale 1ns/1ps
`include "qla_config.svh"

module tb_qla_motor_ctrl;

    localparam int CLK_NS     = 4;
    localparam int RST_CYCLES = 16;
    localparam int NUM_TESTS  = 6;
    localparam int ACK_WAIT   = 8;        // cycles allowed for wb_ack
    localparam int FW         = `QLA_DAC_FRAME_BITS;
    // one frame plus load and gap cycles
    localparam int FRAME_CYC  = FW * 2 * `QLA_DAC_SCLK_DIV + 4;
    localparam int UPDATE_CYC = 2 * `QLA_NUM_CHAN * FRAME_CYC;   // an update plus a pending one
    localparam int LIMIT_CYC  = RST_CYCLES + NUM_TESTS * 4 * UPDATE_CYC + 2000;

    logic                                     sysclk;
    logic                                     rst;
    logic                                     wb_cyc;
    logic                                     wb_stb;
    logic                                     wb_we;
    logic [`QLA_ADDR_W-1:0]                   wb_adr;
    logic [`QLA_DATA_W-1:0]                   wb_dat_i;
    logic [`QLA_DATA_W-1:0]                   wb_dat_o;
    logic                                     wb_ack;
    logic [`QLA_NUM_CHAN-1:0][`QLA_CUR_W-1:0] cur_fb;
    logic [`QLA_NUM_CHAN-1:0]                 amp_enable;
    logic                                     dac_sclk;
    logic                                     dac_mosi;
    logic                                     dac_csn;

    // expected register state, kept by the tests
    logic [`QLA_CUR_W-1:0] exp_cmd  [1:`QLA_NUM_CHAN];
    logic                  exp_en   [1:`QLA_NUM_CHAN];
    logic                  exp_trip [1:`QLA_NUM_CHAN];
    integer                seed;

    logic [FW-1:0] frames [$];            // captured dac frames
    int            frame_len [$];         // bits seen per frame
    logic [FW-1:0] shift_in = '0;
    int            bit_cnt  = 0;

    qla_motor_ctrl dut0 (
        .sysclk     (sysclk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .cur_fb     (cur_fb),
        .amp_enable (amp_enable),
        .dac_sclk   (dac_sclk),
        .dac_mosi   (dac_mosi),
        .dac_csn    (dac_csn)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_NS / 2) sysclk = ~sysclk;
    end

    // ----------------------------------------------------------------------
    // dac serial monitor sampling mosi on rising sclk
    // ----------------------------------------------------------------------
    always @(posedge dac_sclk) begin
        if (dac_csn === 1'b0) begin
            shift_in = {shift_in[FW-2:0], dac_mosi};   // msb arrives first
            bit_cnt  = bit_cnt + 1;
        end
    end

    always @(posedge dac_csn) begin
        if (bit_cnt != 0) begin       // frame closes on csn high
            frames.push_back(shift_in);
            frame_len.push_back(bit_cnt);
            bit_cnt = 0;
        end
    end

    // ----------------------------------------------------------------------
    // failure handling and checks
    // ----------------------------------------------------------------------
    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected 0x%08h, got 0x%08h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    function automatic logic [`QLA_ADDR_W-1:0] reg_addr(input int ch, input logic [3:0] off);
        return {4'(ch), off};         // channel field over offset field
    endfunction

    // expected channel 0 word with busy, trips and enables
    function automatic logic [31:0] board_word(input logic busy);
        logic [31:0] w;
        w    = '0;
        w[8] = busy;
        for (int k = 1; k <= `QLA_NUM_CHAN; k++) begin
            w[3 + k] = exp_trip[k];
            w[k - 1] = exp_en[k];
        end
        return w;
    endfunction

    function automatic logic [31:0] status_word(input int ch);
        return {14'b0, exp_en[ch], exp_trip[ch], exp_cmd[ch]};
    endfunction

    function automatic logic [31:0] en_bits();
        logic [31:0] v;
        v = '0;
        for (int k = 1; k <= `QLA_NUM_CHAN; k++) begin
            v[k - 1] = exp_en[k];
        end
        return v;
    endfunction

    // ----------------------------------------------------------------------
    // wishbone master started on a falling edge
    // ----------------------------------------------------------------------
    task automatic wb_access(input logic we, input logic [`QLA_ADDR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        @(negedge sysclk);
        while (!wb_ack && waited < ACK_WAIT) begin
            @(negedge sysclk);
            waited++;
        end
        if (!wb_ack) begin
            $display("wishbone ack never came for a %s at address 0x%02h",
                     we ? "write" : "read", adr);
            stop_on_failure();
        end else begin
            rdata  = wb_dat_o;        // valid while ack is high
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            @(negedge sysclk);        // ack drops here
        end
    endtask

    task automatic wb_write(input logic [`QLA_ADDR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [`QLA_ADDR_W-1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic set_command(input int ch, input logic [`QLA_CUR_W-1:0] value);
        wb_write(reg_addr(ch, qla_pkg::OFF_DAC_CTRL), 32'(value));
        exp_cmd[ch] = value;
    endtask

    task automatic set_enable(input int ch, input logic en);
        wb_write(reg_addr(ch, qla_pkg::OFF_MOTOR_STATUS), 32'(en));
        exp_en[ch] = en;
        if (en) begin
            exp_trip[ch] = 1'b0;      // re-enable also clears the trip
        end
    endtask

    task automatic drive_feedback(input int ch, input logic [`QLA_CUR_W-1:0] value, input int n);
        cur_fb[ch - 1] = value;
        repeat (n) @(negedge sysclk);
        cur_fb[ch - 1] = '0;
    endtask

    // runaway feedback on one axis just over the margin
    task automatic trip_channel(input int ch);
        drive_feedback(ch, exp_cmd[ch] + `QLA_SAFETY_MARGIN + 16'd1, 10);
        exp_en[ch]   = 1'b0;
        exp_trip[ch] = 1'b1;
    endtask

    // poll busy bit 8 until the update and any pending one are done
    task automatic wait_dac_idle();
        logic [31:0] rd;
        int          polls;
        rd    = 32'h100;
        polls = 0;
        while (rd[8] && polls < UPDATE_CYC) begin
            wb_read(reg_addr(0, qla_pkg::OFF_BOARD_CTRL), rd);
            polls++;
        end
        if (rd[8]) begin
            $display("dac update did not finish, busy stayed high");
            stop_on_failure();
        end
    endtask

    task automatic check_frames(input int first);
        logic [FW-1:0] exp;
        for (int k = 1; k <= `QLA_NUM_CHAN; k++) begin
            exp = {`QLA_DAC_CMD_UPDATE, 4'(k - 1), exp_cmd[k]};   // cmd, addr, data
            check_eq($sformatf("dac frame %0d length", first + k - 1),
                     frame_len[first + k - 1], FW);
            check_eq($sformatf("dac frame %0d", first + k - 1), frames[first + k - 1], exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic test_reset_state();
        logic [31:0] rd;
        check_eq("amp_enable", 32'(amp_enable), 32'h0);
        check_eq("wb_ack", 32'(wb_ack), 32'h0);
        check_eq("dac_sclk", 32'(dac_sclk), 32'h0);
        check_eq("dac_csn", 32'(dac_csn), 32'h1);
        wb_read(reg_addr(0, qla_pkg::OFF_BOARD_CTRL), rd);
        check_eq("board status", rd, 32'h0);
    endtask

    task automatic test_register_round_trip();
        logic [31:0] rnd;
        logic [31:0] rd;
        for (int ch = 1; ch <= `QLA_NUM_CHAN; ch++) begin
            rnd = $random(seed);
            set_command(ch, rnd[15:0]);
        end
        for (int ch = 1; ch <= `QLA_NUM_CHAN; ch++) begin
            wb_read(reg_addr(ch, qla_pkg::OFF_DAC_CTRL), rd);
            check_eq($sformatf("cur_cmd[%0d]", ch), rd, 32'(exp_cmd[ch]));
            set_enable(ch, 1'b1);
            wb_read(reg_addr(ch, qla_pkg::OFF_MOTOR_STATUS), rd);
            check_eq($sformatf("status[%0d]", ch), rd, status_word(ch));
        end
        wait_dac_idle();
    endtask

    task automatic test_dac_update();
        logic [31:0] rnd;
        wait_dac_idle();
        frames.delete();
        frame_len.delete();
        rnd = $random(seed);
        set_command(2, rnd[15:0]);
        wait_dac_idle();
        check_eq("dac_csn", 32'(dac_csn), 32'h1);
        check_eq("dac frame count", frames.size(), 4);
        check_frames(0);
        // later writes land while busy and must reach a second update
        for (int ch = 1; ch <= `QLA_NUM_CHAN; ch += 2) begin
            rnd = $random(seed);
            set_command(ch, rnd[15:0]);
        end
        rnd = $random(seed);
        set_command(4, rnd[15:0]);
        wait_dac_idle();
        check_eq("dac frame count", frames.size(), 12);
        check_frames(8);
    endtask

    task automatic test_safety_trip();
        logic [31:0] rnd;
        logic [31:0] rd;
        rnd = $random(seed);
        set_command(2, rnd[14:0]);    // keep command + margin in range
        rnd = $random(seed);
        set_command(3, rnd[14:0]);
        wait_dac_idle();
        trip_channel(2);
        check_eq("amp_enable", 32'(amp_enable), en_bits());
        wb_read(reg_addr(0, qla_pkg::OFF_BOARD_CTRL), rd);
        check_eq("board status", rd, board_word(1'b0));
        // right at the margin is still fine
        drive_feedback(3, exp_cmd[3] + `QLA_SAFETY_MARGIN, 10);
        check_eq("amp_enable", 32'(amp_enable), en_bits());
        wb_read(reg_addr(3, qla_pkg::OFF_MOTOR_STATUS), rd);
        check_eq("status[3]", rd, status_word(3));
    endtask

    task automatic test_clear_trips();
        logic [31:0] rd;
        set_command(4, 16'h0100);
        wait_dac_idle();
        trip_channel(4);
        wb_write(reg_addr(0, qla_pkg::OFF_BOARD_CTRL), 32'h1);
        for (int k = 1; k <= `QLA_NUM_CHAN; k++) begin
            exp_trip[k] = 1'b0;       // enables stay off
        end
        wb_read(reg_addr(0, qla_pkg::OFF_BOARD_CTRL), rd);
        check_eq("board status", rd, board_word(1'b0));
        check_eq("amp_enable", 32'(amp_enable), en_bits());
        trip_channel(2);
        wb_read(reg_addr(0, qla_pkg::OFF_BOARD_CTRL), rd);
        check_eq("board status", rd, board_word(1'b0));
        set_enable(2, 1'b1);
        wb_read(reg_addr(2, qla_pkg::OFF_MOTOR_STATUS), rd);
        check_eq("status[2]", rd, status_word(2));
        check_eq("amp_enable", 32'(amp_enable), en_bits());
    endtask

    task automatic test_unmapped_reads();
        logic [31:0] rd;
        for (int ch = 0; ch < 16; ch++) begin
            for (int off = 0; off < 16; off++) begin
                if (!((ch == 0 && off == 0) ||
                      (ch >= 1 && ch <= `QLA_NUM_CHAN && off <= 1))) begin
                    wb_read(reg_addr(ch, 4'(off)), rd);
                    check_eq($sformatf("read ch %0d off %0d", ch, off), rd, 32'h0);
                end
            end
        end
    endtask

    // watchdog sized from the test count and the longest dac update
    initial begin
        #(LIMIT_CYC * CLK_NS);
        $display("timeout: tests did not finish within %0d cycles", LIMIT_CYC);
        stop_on_failure();
    end

    initial begin
        seed     = 32'h7c02_bac2;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        cur_fb   = '0;
        for (int k = 1; k <= `QLA_NUM_CHAN; k++) begin
            exp_cmd[k]  = '0;
            exp_en[k]   = 1'b0;
            exp_trip[k] = 1'b0;
        end
        repeat (RST_CYCLES) @(negedge sysclk);
        rst = 1'b0;
        @(negedge sysclk);
        test_reset_state();
        test_register_round_trip();
        test_dac_update();
        test_safety_trip();
        test_clear_trips();
        test_unmapped_reads();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: qla_motor_ctrl.f
+incdir+logic
logic/qla_pkg.sv
logic/reg_bus_if.sv
logic/wb_reg_decode.sv
logic/motor_channel.sv
logic/dac_update_fsm.sv
logic/spi_bit_timer.sv
logic/qla_motor_ctrl.sv
test/tb_qla_motor_ctrl.sv

// File: Bender.yml
package:
  name: qla_motor_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/qla_pkg.sv
      - logic/reg_bus_if.sv
      - logic/wb_reg_decode.sv
      - logic/motor_channel.sv
      - logic/dac_update_fsm.sv
      - logic/spi_bit_timer.sv
      - logic/qla_motor_ctrl.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_qla_motor_ctrl.sv
